// ==== hw/gpu_mem_pkg.sv ====
package gpu_mem_pkg;

	// --------------------------------------------------
	// warp geometry
	// --------------------------------------------------

	localparam int NUM_LANES = 8;
	localparam int WORD_W = 32;
	localparam int WORD_SEL_W = 3;
	localparam int BLOCK_W = 27;
	localparam int LAT_W = 5;

	// byte address bit where the block number starts.
	localparam int BLOCK_LSB = 5;

	// byte address bit where the word select starts.
	localparam int SEL_LSB = 2;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [NUM_LANES*WORD_W-1:0] lane_vec_t;
	typedef logic [BLOCK_W-1:0] block_addr_t;
	typedef logic [WORD_SEL_W-1:0] word_sel_t;
	typedef logic [NUM_LANES*WORD_SEL_W-1:0] word_offsets_t;
	typedef logic [NUM_LANES-1:0] lane_mask_t;
	typedef logic [2:0] warp_id_t;
	typedef logic [1:0] scb_id_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [LAT_W-1:0] latency_t;

	// --------------------------------------------------
	// miss tracker states
	// --------------------------------------------------

	typedef enum logic
	{
		MT_IDLE,
		MT_WAIT
	} miss_state_e;

endpackage

// ==== hw/mem_addr_select.sv ====
`timescale 1ns/1ps

module mem_addr_select
(
	input  logic                     clk,
	input  logic                     resetb,
	input  logic                     req_valid_i,
	input  logic                     mem_read_i,
	input  logic                     mem_write_i,
	input  logic                     shared_i,
	input  gpu_mem_pkg::lane_mask_t  pam_i,
	input  gpu_mem_pkg::lane_vec_t   eff_addr_i,
	input  gpu_mem_pkg::lane_vec_t   write_data_i,
	input  gpu_mem_pkg::warp_id_t    warp_id_i,
	input  gpu_mem_pkg::scb_id_t     scb_id_i,
	input  gpu_mem_pkg::reg_addr_t   reg_addr_i,
	output logic                     s1_valid_o,
	output logic                     s1_read_o,
	output logic                     s1_write_o,
	output logic                     s1_shared_o,
	output gpu_mem_pkg::lane_mask_t  s1_pam_o,
	output gpu_mem_pkg::lane_vec_t   s1_eff_addr_o,
	output gpu_mem_pkg::lane_vec_t   s1_write_data_o,
	output gpu_mem_pkg::warp_id_t    s1_warp_id_o,
	output gpu_mem_pkg::scb_id_t     s1_scb_id_o,
	output gpu_mem_pkg::reg_addr_t   s1_reg_addr_o,
	output gpu_mem_pkg::block_addr_t s1_block_o,
	output logic                     lookup_o
);

	gpu_mem_pkg::block_addr_t sel_block;

	// the lowest active lane wins, so scan from the top down.
	always_comb
	begin
		sel_block = '0;
		for (int lane = gpu_mem_pkg::NUM_LANES - 1; lane >= 0; lane--)
		begin
			if (pam_i[lane])
				sel_block = eff_addr_i[lane*gpu_mem_pkg::WORD_W + gpu_mem_pkg::BLOCK_LSB
					+: gpu_mem_pkg::BLOCK_W];
		end
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			s1_valid_o <= 1'b0;
			s1_read_o <= 1'b0;
			s1_write_o <= 1'b0;
			s1_shared_o <= 1'b0;
			lookup_o <= 1'b0;
		end
		else
		begin
			s1_valid_o <= req_valid_i;
			s1_read_o <= req_valid_i && mem_read_i;
			s1_write_o <= req_valid_i && mem_write_i;
			s1_shared_o <= req_valid_i && shared_i;
			// shared accesses never touch the tag store.
			lookup_o <= req_valid_i && !shared_i && (mem_read_i || mem_write_i);
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid_i)
		begin
			s1_pam_o <= pam_i;
			s1_eff_addr_o <= eff_addr_i;
			s1_write_data_o <= write_data_i;
			s1_warp_id_o <= warp_id_i;
			s1_scb_id_o <= scb_id_i;
			s1_reg_addr_o <= reg_addr_i;
			s1_block_o <= sel_block;
		end
	end

endmodule

// ==== hw/cache_latency_emulator.sv ====
`timescale 1ns/1ps

module cache_latency_emulator
#(
	parameter int cache_lines = 32,
	parameter int lat_addr_w = 8
)
(
	input  logic                     clk,
	input  logic                     resetb,
	input  logic                     lookup_i,
	input  gpu_mem_pkg::block_addr_t block_i,
	input  logic                     cfg_lat_write_i,
	input  logic [lat_addr_w-1:0]    cfg_lat_addr_i,
	input  gpu_mem_pkg::latency_t    cfg_lat_value_i,
	input  logic                     fill_valid_i,
	input  gpu_mem_pkg::block_addr_t fill_block_i,
	input  logic                     busy_i,
	output logic                     hit_o,
	output gpu_mem_pkg::latency_t    latency_o,
	output logic                     miss_wait_o,
	output logic                     miss_start_o,
	output gpu_mem_pkg::block_addr_t miss_block_o
);

	localparam int IDX_W = $clog2(cache_lines);
	localparam int TAG_W = gpu_mem_pkg::BLOCK_W - IDX_W;
	localparam int LAT_DEPTH = 1 << lat_addr_w;

	logic [TAG_W-1:0] tag_mem [cache_lines];
	logic [cache_lines-1:0] tag_valid;
	gpu_mem_pkg::latency_t lat_table [LAT_DEPTH];

	logic [IDX_W-1:0] lookup_idx;
	logic [TAG_W-1:0] lookup_tag;
	logic [IDX_W-1:0] fill_idx;
	logic [lat_addr_w-1:0] lat_idx;
	logic lookup_hit;
	logic start_ok;

	// --------------------------------------------------
	// tag lookup
	// --------------------------------------------------

	assign lookup_idx = block_i[IDX_W-1:0];
	assign lookup_tag = block_i[gpu_mem_pkg::BLOCK_W-1:IDX_W];
	assign fill_idx = fill_block_i[IDX_W-1:0];
	assign lat_idx = block_i[lat_addr_w-1:0];

	assign lookup_hit = tag_valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);

	// only one miss is tracked; a start already in flight counts as busy.
	assign start_ok = lookup_i && !lookup_hit && !busy_i && !miss_start_o;

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			hit_o <= 1'b0;
			miss_start_o <= 1'b0;
			miss_wait_o <= 1'b0;
			tag_valid <= '0;
		end
		else
		begin
			miss_start_o <= start_ok;
			if (lookup_i)
				hit_o <= lookup_hit;
			if (fill_valid_i)
				tag_valid[fill_idx] <= 1'b1;
			// wait spans from the tracker load up to and including the fill.
			if (miss_start_o)
				miss_wait_o <= 1'b1;
			else if (fill_valid_i)
				miss_wait_o <= 1'b0;
		end
	end

	// --------------------------------------------------
	// storage and miss payload
	// --------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (fill_valid_i)
			tag_mem[fill_idx] <= fill_block_i[gpu_mem_pkg::BLOCK_W-1:IDX_W];
		if (cfg_lat_write_i)
			lat_table[cfg_lat_addr_i] <= cfg_lat_value_i;
		if (lookup_i && !lookup_hit)
			latency_o <= lat_table[lat_idx];
		if (start_ok)
			miss_block_o <= block_i;
	end

	a_hit_excludes_start: assert property (
		@(posedge clk) disable iff (!resetb)
		!(hit_o && miss_start_o)
	);

endmodule

// ==== hw/miss_tracker.sv ====
`timescale 1ns/1ps

module miss_tracker
(
	input  logic                     clk,
	input  logic                     resetb,
	input  logic                     miss_start_i,
	input  gpu_mem_pkg::block_addr_t miss_block_i,
	input  gpu_mem_pkg::latency_t    latency_i,
	output logic                     busy_o,
	output logic                     fill_valid_o,
	output gpu_mem_pkg::block_addr_t fill_block_o
);

	gpu_mem_pkg::miss_state_e state_q;
	gpu_mem_pkg::latency_t count_q;
	gpu_mem_pkg::latency_t load_count;

	// a zero entry still takes one cycle.
	assign load_count = (latency_i == '0) ? gpu_mem_pkg::latency_t'(1) : latency_i;

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			state_q <= gpu_mem_pkg::MT_IDLE;
			count_q <= '0;
		end
		else
		begin
			case (state_q)
				gpu_mem_pkg::MT_IDLE:
				begin
					if (miss_start_i)
					begin
						state_q <= gpu_mem_pkg::MT_WAIT;
						count_q <= load_count;
					end
				end
				gpu_mem_pkg::MT_WAIT:
				begin
					if (count_q == gpu_mem_pkg::latency_t'(1))
						state_q <= gpu_mem_pkg::MT_IDLE;
					else
						count_q <= count_q - 1'b1;
				end
				default:
				begin
					state_q <= gpu_mem_pkg::MT_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_start_i && (state_q == gpu_mem_pkg::MT_IDLE))
			fill_block_o <= miss_block_i;
	end

	assign busy_o = (state_q == gpu_mem_pkg::MT_WAIT);
	assign fill_valid_o = busy_o && (count_q == gpu_mem_pkg::latency_t'(1));

	a_fill_ends_wait: assert property (
		@(posedge clk) disable iff (!resetb)
		fill_valid_o |=> (state_q == gpu_mem_pkg::MT_IDLE) && !fill_valid_o
	);

	// the emulator must hold off new misses while one is pending.
	a_no_start_in_wait: assert property (
		@(posedge clk) disable iff (!resetb)
		miss_start_i |-> (state_q == gpu_mem_pkg::MT_IDLE)
	);

endmodule

// ==== hw/mem_coalesce_stage.sv ====
`timescale 1ns/1ps

module mem_coalesce_stage
(
	input  logic                       clk,
	input  logic                       resetb,
	input  logic                       s1_valid_i,
	input  logic                       s1_read_i,
	input  logic                       s1_write_i,
	input  logic                       s1_shared_i,
	input  gpu_mem_pkg::lane_mask_t    s1_pam_i,
	input  gpu_mem_pkg::lane_vec_t     s1_eff_addr_i,
	input  gpu_mem_pkg::lane_vec_t     s1_write_data_i,
	input  gpu_mem_pkg::warp_id_t      s1_warp_id_i,
	input  gpu_mem_pkg::scb_id_t       s1_scb_id_i,
	input  gpu_mem_pkg::reg_addr_t     s1_reg_addr_i,
	input  gpu_mem_pkg::block_addr_t   s1_block_i,
	input  logic                       hit_i,
	output logic                       addr_valid_o,
	output logic                       mem_read_o,
	output logic                       mem_write_o,
	output gpu_mem_pkg::block_addr_t   mem_addr_o,
	output gpu_mem_pkg::lane_vec_t     write_data_o,
	output gpu_mem_pkg::lane_mask_t    mem_write_mask_o,
	output gpu_mem_pkg::lane_mask_t    thread_mask_o,
	output gpu_mem_pkg::word_offsets_t word_offset_o,
	output gpu_mem_pkg::warp_id_t      warp_id_o,
	output gpu_mem_pkg::scb_id_t       scb_id_o,
	output gpu_mem_pkg::reg_addr_t     reg_addr_o
);

	gpu_mem_pkg::lane_mask_t tmask;
	gpu_mem_pkg::word_offsets_t offsets;
	gpu_mem_pkg::lane_mask_t wmask;
	gpu_mem_pkg::lane_vec_t wdata;
	gpu_mem_pkg::lane_mask_t slot_covered;
	logic read_q;
	logic write_q;
	logic shared_q;

	// --------------------------------------------------
	// thread mask and word offsets
	// --------------------------------------------------

	always_comb
	begin
		gpu_mem_pkg::word_t lane_addr;
		for (int lane = 0; lane < gpu_mem_pkg::NUM_LANES; lane++)
		begin
			lane_addr = s1_eff_addr_i[lane*gpu_mem_pkg::WORD_W +: gpu_mem_pkg::WORD_W];
			tmask[lane] = s1_pam_i[lane] &&
				(lane_addr[gpu_mem_pkg::WORD_W-1:gpu_mem_pkg::BLOCK_LSB] == s1_block_i);
			offsets[lane*gpu_mem_pkg::WORD_SEL_W +: gpu_mem_pkg::WORD_SEL_W] =
				lane_addr[gpu_mem_pkg::SEL_LSB +: gpu_mem_pkg::WORD_SEL_W];
		end
	end

	// --------------------------------------------------
	// write coalescing
	// --------------------------------------------------

	// lanes are scanned downward so the lowest lane on a slot ends up owning it.
	always_comb
	begin
		for (int slot = 0; slot < gpu_mem_pkg::NUM_LANES; slot++)
		begin
			wmask[slot] = 1'b0;
			wdata[slot*gpu_mem_pkg::WORD_W +: gpu_mem_pkg::WORD_W] =
				s1_write_data_i[gpu_mem_pkg::WORD_W-1:0];
			for (int lane = gpu_mem_pkg::NUM_LANES - 1; lane >= 0; lane--)
			begin
				if (tmask[lane] && (offsets[lane*gpu_mem_pkg::WORD_SEL_W +: gpu_mem_pkg::WORD_SEL_W]
					== gpu_mem_pkg::word_sel_t'(slot)))
				begin
					wmask[slot] = 1'b1;
					wdata[slot*gpu_mem_pkg::WORD_W +: gpu_mem_pkg::WORD_W] =
						s1_write_data_i[lane*gpu_mem_pkg::WORD_W +: gpu_mem_pkg::WORD_W];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			addr_valid_o <= 1'b0;
			read_q <= 1'b0;
			write_q <= 1'b0;
			shared_q <= 1'b0;
		end
		else
		begin
			addr_valid_o <= s1_valid_i;
			read_q <= s1_read_i;
			write_q <= s1_write_i;
			shared_q <= s1_shared_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid_i)
		begin
			mem_addr_o <= s1_block_i;
			write_data_o <= wdata;
			mem_write_mask_o <= wmask;
			thread_mask_o <= tmask;
			word_offset_o <= offsets;
			warp_id_o <= s1_warp_id_i;
			scb_id_o <= s1_scb_id_i;
			reg_addr_o <= s1_reg_addr_i;
		end
	end

	// a global access only issues on a hit; shared always goes.
	assign mem_read_o = read_q && (hit_i || shared_q);
	assign mem_write_o = write_q && (hit_i || shared_q);

	always_comb
	begin
		for (int slot = 0; slot < gpu_mem_pkg::NUM_LANES; slot++)
		begin
			slot_covered[slot] = 1'b0;
			for (int lane = 0; lane < gpu_mem_pkg::NUM_LANES; lane++)
			begin
				if (thread_mask_o[lane] &&
					(word_offset_o[lane*gpu_mem_pkg::WORD_SEL_W +: gpu_mem_pkg::WORD_SEL_W]
					== gpu_mem_pkg::word_sel_t'(slot)))
					slot_covered[slot] = 1'b1;
			end
		end
	end

	a_mask_has_owner: assert property (
		@(posedge clk) disable iff (!resetb)
		addr_valid_o |-> ((mem_write_mask_o & ~slot_covered) == '0)
	);

endmodule

// ==== hw/gpu_mem_top.sv ====
`timescale 1ns/1ps

module gpu_mem_top
#(
	parameter int cache_lines = 32,
	parameter int lat_addr_w = 8
)
(
	input  logic                       clk,
	input  logic                       resetb,
	input  logic                       req_valid_i,
	input  logic                       mem_read_i,
	input  logic                       mem_write_i,
	input  logic                       shared_i,
	input  gpu_mem_pkg::lane_mask_t    pam_i,
	input  gpu_mem_pkg::lane_vec_t     eff_addr_i,
	input  gpu_mem_pkg::lane_vec_t     write_data_i,
	input  gpu_mem_pkg::warp_id_t      warp_id_i,
	input  gpu_mem_pkg::scb_id_t       scb_id_i,
	input  gpu_mem_pkg::reg_addr_t     reg_addr_i,
	input  logic                       cfg_lat_write_i,
	input  logic [lat_addr_w-1:0]      cfg_lat_addr_i,
	input  gpu_mem_pkg::latency_t      cfg_lat_value_i,
	output logic                       addr_valid_o,
	output logic                       mem_read_o,
	output logic                       mem_write_o,
	output gpu_mem_pkg::block_addr_t   mem_addr_o,
	output gpu_mem_pkg::lane_vec_t     write_data_o,
	output gpu_mem_pkg::lane_mask_t    mem_write_mask_o,
	output gpu_mem_pkg::lane_mask_t    thread_mask_o,
	output gpu_mem_pkg::word_offsets_t word_offset_o,
	output gpu_mem_pkg::warp_id_t      warp_id_o,
	output gpu_mem_pkg::scb_id_t       scb_id_o,
	output gpu_mem_pkg::reg_addr_t     reg_addr_o,
	output logic                       hit_o,
	output logic                       miss_wait_o,
	output gpu_mem_pkg::latency_t      miss_latency_o,
	output logic                       fill_valid_o,
	output gpu_mem_pkg::block_addr_t   fill_addr_o
);

	logic s1_valid;
	logic s1_read;
	logic s1_write;
	logic s1_shared;
	gpu_mem_pkg::lane_mask_t s1_pam;
	gpu_mem_pkg::lane_vec_t s1_eff_addr;
	gpu_mem_pkg::lane_vec_t s1_write_data;
	gpu_mem_pkg::warp_id_t s1_warp_id;
	gpu_mem_pkg::scb_id_t s1_scb_id;
	gpu_mem_pkg::reg_addr_t s1_reg_addr;
	gpu_mem_pkg::block_addr_t s1_block;
	logic s1_lookup;
	logic miss_start;
	gpu_mem_pkg::block_addr_t miss_block;
	logic tracker_busy;

	mem_addr_select u_addr_select (
		.clk(clk), .resetb(resetb), .req_valid_i(req_valid_i),
		.mem_read_i(mem_read_i), .mem_write_i(mem_write_i), .shared_i(shared_i),
		.pam_i(pam_i), .eff_addr_i(eff_addr_i), .write_data_i(write_data_i),
		.warp_id_i(warp_id_i), .scb_id_i(scb_id_i), .reg_addr_i(reg_addr_i),
		.s1_valid_o(s1_valid), .s1_read_o(s1_read), .s1_write_o(s1_write),
		.s1_shared_o(s1_shared), .s1_pam_o(s1_pam), .s1_eff_addr_o(s1_eff_addr),
		.s1_write_data_o(s1_write_data), .s1_warp_id_o(s1_warp_id),
		.s1_scb_id_o(s1_scb_id), .s1_reg_addr_o(s1_reg_addr),
		.s1_block_o(s1_block), .lookup_o(s1_lookup)
	);

	cache_latency_emulator #(.cache_lines(cache_lines), .lat_addr_w(lat_addr_w)) u_emulator (
		.clk(clk), .resetb(resetb), .lookup_i(s1_lookup), .block_i(s1_block),
		.cfg_lat_write_i(cfg_lat_write_i), .cfg_lat_addr_i(cfg_lat_addr_i),
		.cfg_lat_value_i(cfg_lat_value_i), .fill_valid_i(fill_valid_o),
		.fill_block_i(fill_addr_o), .busy_i(tracker_busy), .hit_o(hit_o),
		.latency_o(miss_latency_o), .miss_wait_o(miss_wait_o),
		.miss_start_o(miss_start), .miss_block_o(miss_block)
	);

	miss_tracker u_tracker (
		.clk(clk), .resetb(resetb), .miss_start_i(miss_start),
		.miss_block_i(miss_block), .latency_i(miss_latency_o),
		.busy_o(tracker_busy), .fill_valid_o(fill_valid_o), .fill_block_o(fill_addr_o)
	);

	mem_coalesce_stage u_coalesce (
		.clk(clk), .resetb(resetb), .s1_valid_i(s1_valid), .s1_read_i(s1_read),
		.s1_write_i(s1_write), .s1_shared_i(s1_shared), .s1_pam_i(s1_pam),
		.s1_eff_addr_i(s1_eff_addr), .s1_write_data_i(s1_write_data),
		.s1_warp_id_i(s1_warp_id), .s1_scb_id_i(s1_scb_id),
		.s1_reg_addr_i(s1_reg_addr), .s1_block_i(s1_block), .hit_i(hit_o),
		.addr_valid_o(addr_valid_o), .mem_read_o(mem_read_o),
		.mem_write_o(mem_write_o), .mem_addr_o(mem_addr_o),
		.write_data_o(write_data_o), .mem_write_mask_o(mem_write_mask_o),
		.thread_mask_o(thread_mask_o), .word_offset_o(word_offset_o),
		.warp_id_o(warp_id_o), .scb_id_o(scb_id_o), .reg_addr_o(reg_addr_o)
	);

endmodule

// ==== sim/tb_gpu_mem.sv ====
`timescale 1ns/1ps

module tb_gpu_mem;

	localparam int MAX_RECS = 64;
	localparam int NUM_FIELDS = 22;

	logic clk;
	logic resetb;
	logic req_valid_i;
	logic mem_read_i;
	logic mem_write_i;
	logic shared_i;
	gpu_mem_pkg::lane_mask_t pam_i;
	gpu_mem_pkg::lane_vec_t eff_addr_i;
	gpu_mem_pkg::lane_vec_t write_data_i;
	gpu_mem_pkg::warp_id_t warp_id_i;
	gpu_mem_pkg::scb_id_t scb_id_i;
	gpu_mem_pkg::reg_addr_t reg_addr_i;
	logic cfg_lat_write_i;
	logic [7:0] cfg_lat_addr_i;
	gpu_mem_pkg::latency_t cfg_lat_value_i;
	logic addr_valid_o;
	logic mem_read_o;
	logic mem_write_o;
	gpu_mem_pkg::block_addr_t mem_addr_o;
	gpu_mem_pkg::lane_vec_t write_data_o;
	gpu_mem_pkg::lane_mask_t mem_write_mask_o;
	gpu_mem_pkg::lane_mask_t thread_mask_o;
	gpu_mem_pkg::word_offsets_t word_offset_o;
	gpu_mem_pkg::warp_id_t warp_id_o;
	gpu_mem_pkg::scb_id_t scb_id_o;
	gpu_mem_pkg::reg_addr_t reg_addr_o;
	logic hit_o;
	logic miss_wait_o;
	gpu_mem_pkg::latency_t miss_latency_o;
	logic fill_valid_o;
	gpu_mem_pkg::block_addr_t fill_addr_o;

	byte rec_kind [MAX_RECS];
	logic [31:0] fld [MAX_RECS][NUM_FIELDS];
	int num_recs;
	bit trace_loaded;
	integer seed;
	int checks;
	int err_value;
	int err_other;

	gpu_mem_top #(.cache_lines(32), .lat_addr_w(8)) UUT (
		.clk(clk), .resetb(resetb), .req_valid_i(req_valid_i),
		.mem_read_i(mem_read_i), .mem_write_i(mem_write_i), .shared_i(shared_i),
		.pam_i(pam_i), .eff_addr_i(eff_addr_i), .write_data_i(write_data_i),
		.warp_id_i(warp_id_i), .scb_id_i(scb_id_i), .reg_addr_i(reg_addr_i),
		.cfg_lat_write_i(cfg_lat_write_i), .cfg_lat_addr_i(cfg_lat_addr_i),
		.cfg_lat_value_i(cfg_lat_value_i), .addr_valid_o(addr_valid_o),
		.mem_read_o(mem_read_o), .mem_write_o(mem_write_o), .mem_addr_o(mem_addr_o),
		.write_data_o(write_data_o), .mem_write_mask_o(mem_write_mask_o),
		.thread_mask_o(thread_mask_o), .word_offset_o(word_offset_o),
		.warp_id_o(warp_id_o), .scb_id_o(scb_id_o), .reg_addr_o(reg_addr_o),
		.hit_o(hit_o), .miss_wait_o(miss_wait_o), .miss_latency_o(miss_latency_o),
		.fill_valid_o(fill_valid_o), .fill_addr_o(fill_addr_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------

	task automatic check_block(input gpu_mem_pkg::block_addr_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_mask(input gpu_mem_pkg::lane_mask_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_offsets(input gpu_mem_pkg::word_offsets_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input gpu_mem_pkg::word_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_latency(input gpu_mem_pkg::latency_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_warp(input gpu_mem_pkg::warp_id_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_scb(input gpu_mem_pkg::scb_id_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input gpu_mem_pkg::reg_addr_t got, exp, input string what);
		checks++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// --------------------------------------------------
	// trace records
	// --------------------------------------------------

	task automatic load_trace();
		integer fd;
		integer code;
		byte kind;
		int count;
		reg [8*256-1:0] rest;
		fd = $fopen("sim/gpu_mem_trace.txt", "r");
		if (fd == 0)
		begin
			err_other++;
			$display("could not open the trace file sim/gpu_mem_trace.txt");
		end
		else
		begin
			code = $fscanf(fd, " %c", kind);
			while (code == 1 && num_recs < MAX_RECS)
			begin
				count = (kind == "C") ? 2 : (kind == "W") ? 3 : (kind == "R") ? NUM_FIELDS : 0;
				if (count == 0)
				begin
					if (kind != "#")
					begin
						err_other++;
						$display("unknown record kind '%c' in the trace file", kind);
					end
					code = $fgets(rest, fd);
				end
				else
				begin
					for (int k = 0; k < count; k++)
						code = $fscanf(fd, " %h", fld[num_recs][k]);
					rec_kind[num_recs] = kind;
					num_recs++;
				end
				code = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
	endtask

	task automatic write_latency(input int i);
		@(posedge clk);
		cfg_lat_write_i <= 1'b1;
		cfg_lat_addr_i <= fld[i][0][7:0];
		cfg_lat_value_i <= fld[i][1][4:0];
		@(posedge clk);
		cfg_lat_write_i <= 1'b0;
	endtask

	// fields 0..11 are stimulus, 12..21 the expected stage 2 results.
	task automatic run_request(input int i);
		int gap;
		gpu_mem_pkg::block_addr_t blk;
		gpu_mem_pkg::lane_vec_t addr_v;
		gpu_mem_pkg::lane_vec_t data_v;
		gpu_mem_pkg::word_t exp_word;
		gap = $unsigned($random(seed)) % 4;
		for (int lane = 0; lane < gpu_mem_pkg::NUM_LANES; lane++)
		begin
			blk = fld[i][6][lane] ? fld[i][5][26:0] : fld[i][4][26:0];
			addr_v[lane*32 +: 32] = {blk, fld[i][7][lane*3 +: 3], 2'b00};
			data_v[lane*32 +: 32] = fld[i][8] + lane;
		end
		repeat (gap) @(posedge clk);
		@(posedge clk);
		req_valid_i <= 1'b1;
		mem_read_i <= fld[i][0][0];
		mem_write_i <= fld[i][1][0];
		shared_i <= fld[i][2][0];
		pam_i <= fld[i][3][7:0];
		eff_addr_i <= addr_v;
		write_data_i <= data_v;
		warp_id_i <= fld[i][9][2:0];
		scb_id_i <= fld[i][10][1:0];
		reg_addr_i <= fld[i][11][4:0];
		@(posedge clk);
		req_valid_i <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_flag(addr_valid_o, 1'b1, "addr_valid_o");
		check_block(mem_addr_o, fld[i][12][26:0], "mem_addr_o");
		check_mask(thread_mask_o, fld[i][13][7:0], "thread_mask_o");
		check_mask(mem_write_mask_o, fld[i][14][7:0], "mem_write_mask_o");
		check_offsets(word_offset_o, fld[i][15][23:0], "word_offset_o");
		for (int slot = 0; slot < gpu_mem_pkg::NUM_LANES; slot++)
		begin
			exp_word = fld[i][8] + {28'd0, fld[i][16][slot*4 +: 4]};
			if (fld[i][14][slot])
				check_word(write_data_o[slot*32 +: 32], exp_word,
					$sformatf("write_data_o[%0d]", slot));
		end
		// the identifiers travel with the request unchanged.
		check_warp(warp_id_o, fld[i][9][2:0], "warp_id_o");
		check_scb(scb_id_o, fld[i][10][1:0], "scb_id_o");
		check_reg(reg_addr_o, fld[i][11][4:0], "reg_addr_o");
		check_flag(hit_o, fld[i][17][0], "hit_o");
		check_flag(miss_wait_o, fld[i][18][0], "miss_wait_o");
		if (!fld[i][2][0] && !fld[i][17][0])
			check_latency(miss_latency_o, fld[i][19][4:0], "miss_latency_o");
		check_flag(mem_read_o, fld[i][20][0], "mem_read_o");
		check_flag(mem_write_o, fld[i][21][0], "mem_write_o");
	endtask

	task automatic wait_record(input int i);
		bit found;
		found = 1'b0;
		if (fld[i][0][0])
		begin
			for (int c = 0; c < fld[i][1] && !found; c++)
			begin
				@(negedge clk);
				found = fill_valid_o;
			end
			if (found)
				check_block(fill_addr_o, fld[i][2][26:0], "fill_addr_o");
			else
			begin
				err_other++;
				$display("no fill arrived within %0d cycles for record %0d", fld[i][1], i);
			end
		end
		else
			repeat (fld[i][1]) @(posedge clk);
	endtask

	// --------------------------------------------------
	// main sequence and watchdog
	// --------------------------------------------------

	initial
	begin
		resetb = 1'b0;
		req_valid_i = 1'b0;
		mem_read_i = 1'b0;
		mem_write_i = 1'b0;
		shared_i = 1'b0;
		pam_i = '0;
		eff_addr_i = '0;
		write_data_i = '0;
		warp_id_i = '0;
		scb_id_i = '0;
		reg_addr_i = '0;
		cfg_lat_write_i = 1'b0;
		cfg_lat_addr_i = '0;
		cfg_lat_value_i = '0;
		seed = 32'h88d5;
		num_recs = 0;
		checks = 0;
		err_value = 0;
		err_other = 0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (10) @(posedge clk);
		resetb <= 1'b1;
		@(negedge clk);
		check_flag(addr_valid_o, 1'b0, "addr_valid_o after reset");
		check_flag(mem_read_o, 1'b0, "mem_read_o after reset");
		check_flag(mem_write_o, 1'b0, "mem_write_o after reset");
		check_flag(fill_valid_o, 1'b0, "fill_valid_o after reset");
		check_flag(miss_wait_o, 1'b0, "miss_wait_o after reset");
		for (int i = 0; i < num_recs; i++)
		begin
			if (rec_kind[i] == "C")
				write_latency(i);
			else if (rec_kind[i] == "R")
				run_request(i);
			else
				wait_record(i);
		end
		$display("checks %0d, value errors %0d, other errors %0d", checks, err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		wait (trace_loaded);
		repeat (num_recs * 40 + 20) @(posedge clk);
		$display("watchdog expired after %0d cycles before the trace completed",
			num_recs * 40 + 20);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== sim/gpu_mem_trace.txt ====
# C lat_index latency | W mode(1 = wait for fill) max_cycles fill_block
# R rd wr sh pam blk_a blk_b b_sel w_sel d_base warp scb reg blk tmask wmask offs owners hit wait lat rd wr
C 10 07
C 20 03
C 30 0c
R 1 0 0 fe 0000010 0000020 5a fac688 a0000000 1 2 05 0000020 5a 5a fac688 06043010 0 0 03 0 0
W 1 30 0000020
R 0 1 0 ff 0000020 0000020 00 43d152 b0000000 2 1 0a 0000020 ff a5 43d152 50200003 1 0 03 0 1
R 1 0 0 01 0000030 0000000 00 fac688 c0000000 3 0 11 0000030 01 01 fac688 00000000 0 0 0c 0 0
R 0 1 1 0f 0000123 0000456 0c fac688 d0000000 4 3 1f 0000123 03 03 fac688 00000010 0 1 0c 0 1
W 1 30 0000030
R 1 0 0 ff 0000010 0000010 00 fac688 e0000000 5 1 02 0000010 ff ff fac688 76543210 0 0 07 0 0
W 1 30 0000010
C 10 09
R 1 0 0 80 0000110 0000010 00 fac688 f0000000 6 2 03 0000110 80 80 fac688 70000000 0 0 09 0 0
W 1 30 0000110
R 1 0 0 81 0000110 0000010 00 fac688 11111110 7 0 04 0000110 81 81 fac688 70000000 1 0 09 1 0
C 50 00
R 0 1 0 04 0000050 0000010 00 fac688 22222220 0 1 06 0000050 04 04 fac688 00000200 0 0 00 0 0
W 1 30 0000050
R 0 1 0 04 0000050 0000010 00 fac688 33333330 1 1 07 0000050 04 04 fac688 00000200 1 0 00 0 1
R 1 0 0 02 0000030 0000010 00 fac688 44444440 2 2 08 0000030 02 02 fac688 00000010 0 0 0c 0 0
W 1 30 0000030
W 0 4 0000000

// ==== sources.f ====
hw/gpu_mem_pkg.sv
hw/mem_addr_select.sv
hw/cache_latency_emulator.sv
hw/miss_tracker.sv
hw/mem_coalesce_stage.sv
hw/gpu_mem_top.sv
sim/tb_gpu_mem.sv

// ==== Bender.yml ====
package:
  name: gpu_mem

sources:
  - hw/gpu_mem_pkg.sv
  - hw/mem_addr_select.sv
  - hw/cache_latency_emulator.sv
  - hw/miss_tracker.sv
  - hw/mem_coalesce_stage.sv
  - hw/gpu_mem_top.sv
  - target: simulation
    files:
      - sim/tb_gpu_mem.sv
